/* alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module alu (
   input  logic                clk,
   input  logic                rst_n,
   input  alu_op_pkg::alu_op_e op,
   input  logic [`ALU_W-1:0]   data_in1,
   input  logic [`ALU_W-1:0]   data_in2,
   output logic [`ALU_W-1:0]   data_out,
   output logic                mult_done
);

   import alu_op_pkg::*;
   import alu_data_pkg::*;

   operand_pair_t                  operands;        // both data inputs as one payload
   operand_pair_t [`ALU_N_OPS-1:0] operand_slots;   // only the selected slot is non-zero
   op_onehot_t                     activate;        // one enable per block
   result_array_t                  gate_results;    // single-cycle results from the gate bank
   result_array_t                  results;         // all sixteen results seen by the mux
   logic [`ALU_W-1:0]              mult_lo;         // low product byte, zero until done
   logic [`ALU_W-1:0]              dec_value;       // register contents for ops 14 and 15

   assign operands = '{a: data_in1, b: data_in2};

   op_demux #(.payload_t(operand_pair_t)) operand_demux_i (
      .op(op), .payload(operands), .slots(operand_slots));

   // the constant one is steered to form the activate vector
   op_demux #(.payload_t(logic)) activate_demux_i (
      .op(op), .payload(1'b1), .slots(activate));

   gate_bank gate_bank_i (.slots(operand_slots), .results_comb(gate_results));

   shift_add_mult shift_add_mult_i (
      .clk(clk), .rst_n(rst_n), .active(activate[op_mul]),
      .operands(operand_slots[op_mul]), .product_lo(mult_lo), .mult_done(mult_done));

   dec_register dec_register_i (
      .clk(clk), .rst_n(rst_n), .dec_en(activate[op_dec]), .load_en(activate[op_load]),
      .load_value(operand_slots[op_load].a), .value(dec_value));

   // sequential block outputs take their own entries in the result array
   always_comb begin
      results          = gate_results;
      results[op_mul]  = mult_lo;
      results[op_dec]  = dec_value;
      results[op_load] = dec_value;  // load reads the current value as well
   end

   result_mux result_mux_i (.op(op), .results(results), .data_out(data_out));

endmodule

`default_nettype wire

/* alu_data_pkg.sv */
`default_nettype none

`include "alu_macros.svh"

package alu_data_pkg;

   // operand pair as it travels through the demux, a in the upper byte
   typedef struct packed {
      logic [`ALU_W-1:0] a;
      logic [`ALU_W-1:0] b;
   } operand_pair_t;

   // compare result byte, lt lands in bit 0 and the top five bits stay zero
   typedef struct packed {
      logic [4:0] rsvd;  // always zero on the bus
      logic       gt;    // a > b unsigned
      logic       eq;    // a == b
      logic       lt;    // a < b unsigned
   } cmp_flags_t;

   // one result byte per opcode, indexed by the opcode value
   typedef logic [`ALU_N_OPS-1:0][`ALU_W-1:0] result_array_t;

endpackage

`default_nettype wire

/* alu_macros.svh */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// width of both operands and of data_out
`define ALU_W 8

// opcode width; four bits select one of the functional slots
`define ALU_OP_W 4

// one slot per opcode value, so 2 ** ALU_OP_W
`define ALU_N_OPS 16

// shift-and-add iterations, one per multiplier bit
`define ALU_MULT_CYCLES 8

`endif

/* alu_op_pkg.sv */
`default_nettype none

`include "alu_macros.svh"

package alu_op_pkg;

   // opcode encoding, the code is also the slot index in every per-op array
   typedef enum logic [`ALU_OP_W-1:0] {
      op_add   = 4'd0,   // a + b, low byte
      op_carry = 4'd1,   // carry out of a + b
      op_half  = 4'd2,   // a shifted right by one
      op_lsb   = 4'd3,   // lowest bit of a
      op_mul   = 4'd4,   // multi-cycle multiply, low byte of the product
      op_cmp   = 4'd5,   // unsigned compare flags of a against b
      op_buf   = 4'd6,   // a passed straight through
      op_not   = 4'd7,   // bitwise not of a
      op_and   = 4'd8,
      op_nand  = 4'd9,
      op_or    = 4'd10,
      op_nor   = 4'd11,
      op_xor   = 4'd12,
      op_xnor  = 4'd13,
      op_dec   = 4'd14,  // read the register and count it down
      op_load  = 4'd15   // read the register and load it from a
   } alu_op_e;

   // activate vector, exactly one bit set for the current opcode
   typedef logic [`ALU_N_OPS-1:0] op_onehot_t;

endpackage

`default_nettype wire

/* alu_trace.txt */
# columns: mode opcode data_in1 data_in2 expected_data_out, numbers in hex
# mode C samples after one cycle, S after one more edge, M waits for mult_done
# reset state, op 14 reads zero and counts the register down to ff
C e 00 00 00
# add keeps the low byte, carry gives 0 or 1
C 0 00 00 00
C 0 ff 01 00
C 0 7f 01 80
C 0 ff ff fe
C 1 ff 01 01
C 1 80 7f 00
C 1 80 80 01
C 1 00 00 00
# halve and lowest bit of a
C 2 ff 00 7f
C 2 80 00 40
C 2 01 00 00
C 3 ff 00 01
C 3 80 00 00
C 3 01 00 01
# unsigned compare, lt then eq then gt
C 5 01 80 01
C 5 80 80 02
C 5 ff 00 04
# buf, not and the two-input gates
C 6 80 ff 80
C 7 80 00 7f
C 7 00 ff ff
C 8 ff 80 80
C 9 ff 80 7f
C a 80 01 81
C b 80 01 7e
C c ff 80 7f
C d ff 80 80
C c 01 01 00
C d 01 01 ff
# multiply, low byte of the product only
M 4 0f 11 ff
M 4 ff ff 01
M 4 00 37 00
M 4 12 34 a8
# one edge of a run, op moves away, then a new run with new operands
S 4 0f 11 00
C 6 55 00 55
M 4 03 05 0f
# load reads the old value, each op 14 reads then counts down
C f 03 00 ff
C e 00 00 03
C e 00 00 02
C e 00 00 01
C e 00 00 00
C e 00 00 ff
S f 42 00 42
C e 00 00 42

/* dec_register.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module dec_register (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              dec_en,
   input  logic              load_en,
   input  logic [`ALU_W-1:0] load_value,
   output logic [`ALU_W-1:0] value
);

   logic [`ALU_W-1:0] count_q;  // stored value, what both ops read this cycle

   // the read shows the value from before the edge, the update lands after it
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count_q <= '0;
      end else if (load_en) begin
         count_q <= load_value;           // op 15 takes operand a
      end else if (dec_en) begin
         count_q <= count_q - 1'b1;       // wraps from 00 to FF
      end
   end

   assign value = count_q;

   // both enables come from one decoded opcode, so they must never overlap
   a_enables_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(dec_en && load_en))
      else $error("dec_register saw load and decrement together");

endmodule

`default_nettype wire

/* gate_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module gate_bank (
   input  alu_data_pkg::operand_pair_t [`ALU_N_OPS-1:0] slots,
   output alu_data_pkg::result_array_t                  results_comb
);

   import alu_op_pkg::*;
   import alu_data_pkg::*;

   logic [`ALU_W-1:0] sum_wide;   // low byte of a + b for op 0
   logic [`ALU_W:0]   carry_wide; // nine bits so the carry out of the op 1 sum is kept
   cmp_flags_t        flags;      // compare result before it goes on the byte bus

   // add and carry get separate adders since each one reads its own slot
   assign sum_wide   = slots[op_add].a + slots[op_add].b;
   assign carry_wide = {1'b0, slots[op_carry].a} + {1'b0, slots[op_carry].b};

   // unsigned compare of the op 5 slot
   always_comb begin
      flags      = '0;
      flags.lt   = (slots[op_cmp].a <  slots[op_cmp].b);
      flags.eq   = (slots[op_cmp].a == slots[op_cmp].b);
      flags.gt   = (slots[op_cmp].a >  slots[op_cmp].b);
   end

   always_comb begin
      results_comb = '0;  // entries for mul, dec and load are filled elsewhere

      results_comb[op_add]   = sum_wide;
      results_comb[op_carry] = {{(`ALU_W-1){1'b0}}, carry_wide[`ALU_W]}; // 0 or 1

      results_comb[op_half]  = slots[op_half].a >> 1;               // zero fills the top bit
      results_comb[op_lsb]   = {{(`ALU_W-1){1'b0}}, slots[op_lsb].a[0]};

      results_comb[op_cmp]   = flags;

      results_comb[op_buf]   = slots[op_buf].a;
      results_comb[op_not]   = ~slots[op_not].a;

      // b only matters in this two-input group and in add and compare
      results_comb[op_and]   = slots[op_and].a & slots[op_and].b;
      results_comb[op_nand]  = ~(slots[op_nand].a & slots[op_nand].b);
      results_comb[op_or]    = slots[op_or].a | slots[op_or].b;
      results_comb[op_nor]   = ~(slots[op_nor].a | slots[op_nor].b);
      results_comb[op_xor]   = slots[op_xor].a ^ slots[op_xor].b;
      results_comb[op_xnor]  = ~(slots[op_xnor].a ^ slots[op_xnor].b);
   end

endmodule

`default_nettype wire

/* op_demux.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module op_demux #(
   parameter type payload_t = logic  // any packed payload, one bit up to a whole struct
) (
   input  alu_op_pkg::alu_op_e        op,
   input  payload_t                   payload,
   output payload_t [`ALU_N_OPS-1:0]  slots
);

   logic [`ALU_N_OPS-1:0] slot_busy;  // one flag per slot that carries something

   // flat decoder, the selected slot gets the payload and the rest read zero
   always_comb begin
      for (int i = 0; i < `ALU_N_OPS; i++) begin
         if (op == i) begin
            slots[i] = payload;  // this is the block the opcode steers to
         end else begin
            slots[i] = '0;       // idle blocks see quiet inputs
         end
      end
   end

   always_comb begin
      for (int i = 0; i < `ALU_N_OPS; i++) begin
         slot_busy[i] = (slots[i] != '0);
      end
   end

   // downstream blocks rely on seeing at most one live operand set
   always_comb begin
      assert ($onehot0(slot_busy))
         else $error("op_demux drives more than one slot, op %0d", op);
   end

endmodule

`default_nettype wire

/* result_mux.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module result_mux (
   input  alu_op_pkg::alu_op_e     op,
   input  alu_data_pkg::result_array_t results,
   output logic [`ALU_W-1:0]       data_out
);

   logic [`ALU_OP_W-1:0] sel;           // opcode as plain bits, one bit per tree level
   logic [`ALU_W-1:0]    lvl_a [8];     // first level, pairs picked by sel[0]
   logic [`ALU_W-1:0]    lvl_b [4];     // second level, picked by sel[1]
   logic [`ALU_W-1:0]    lvl_c [2];     // third level, picked by sel[2]

   assign sel = op;

   // four 2:1 stages, the lowest opcode bit splits neighbouring results first
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         lvl_a[i] = sel[0] ? results[2*i+1] : results[2*i];
      end
      for (int i = 0; i < 4; i++) begin
         lvl_b[i] = sel[1] ? lvl_a[2*i+1] : lvl_a[2*i];
      end
      for (int i = 0; i < 2; i++) begin
         lvl_c[i] = sel[2] ? lvl_b[2*i+1] : lvl_b[2*i];
      end
      data_out = sel[3] ? lvl_c[1] : lvl_c[0];  // root of the tree
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the ALU testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_alu -f vlog.f -o sim_alu

# the log decides the result, so a failing run must not stop the script here
./obj_dir/sim_alu > sim.log 2>&1 || true
cat sim.log

if grep -q "PASS: all tests" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* shift_add_mult.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module shift_add_mult (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        active,
   input  alu_data_pkg::operand_pair_t operands,
   output logic [`ALU_W-1:0]           product_lo,
   output logic                        mult_done
);

   logic [3:0]          count;   // iterations done, 0 means idle or aborted
   logic [2*`ALU_W-1:0] mcand;   // multiplicand, shifted left one place per iteration
   logic [`ALU_W-1:0]   mplier;  // multiplier, its low bit decides each add
   logic [2*`ALU_W-1:0] acc;     // running product, the top byte is never read out
   logic                finished;

   // control state clears on reset and whenever op 4 goes away
   always_ff @(posedge clk) begin
      if (!rst_n || !active) begin
         count <= '0;
      end else if (count != 4'(`ALU_MULT_CYCLES)) begin
         count <= count + 4'd1;  // holds at the final count until the op changes
      end
   end

   // datapath, the first active cycle takes the operands and does iteration one
   always_ff @(posedge clk) begin
      if (active && count == '0) begin
         acc    <= operands.b[0] ? {{`ALU_W{1'b0}}, operands.a} : '0;
         mcand  <= {{(`ALU_W-1){1'b0}}, operands.a, 1'b0};
         mplier <= operands.b >> 1;
      end else if (active && count != 4'(`ALU_MULT_CYCLES)) begin
         if (mplier[0]) begin
            acc <= acc + mcand;  // add the shifted multiplicand for a set bit
         end
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

   assign finished   = (count == 4'(`ALU_MULT_CYCLES));
   assign mult_done  = active & finished;  // drops as soon as the opcode moves on
   assign product_lo = mult_done ? acc[`ALU_W-1:0] : '0;  // zero until the run completes

   // done can only appear after an edge where the multiply was still selected
   a_done_after_active: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(mult_done) |-> $past(active))
      else $error("mult_done rose without op 4 held");

   a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
      count <= 4'(`ALU_MULT_CYCLES))
      else $error("multiplier counter ran past %0d", `ALU_MULT_CYCLES);

endmodule

`default_nettype wire

/* tb_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module tb_clock_gen (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always begin
      #5 clk = ~clk;  // 10 ns period
   end

endmodule

module tb_alu;

   import alu_op_pkg::*;

   localparam int MULT_TIMEOUT = 20;  // cycles allowed for mult_done to rise
   localparam int RESET_CYCLES = 5;
   localparam int MAX_GAP      = 3;   // idle gaps of 0 to 2 cycles between lines

   logic              clk;
   logic              rst_n;
   alu_op_e           op;
   logic [`ALU_W-1:0] data_in1;
   logic [`ALU_W-1:0] data_in2;
   logic [`ALU_W-1:0] data_out;
   logic              mult_done;

   int trace_fd;   // handle of the open trace file
   int lines_run;  // trace lines that went through the DUT

   tb_clock_gen clock_gen_i (.clk(clk));

   alu dut_i (
      .clk(clk), .rst_n(rst_n), .op(op), .data_in1(data_in1), .data_in2(data_in2),
      .data_out(data_out), .mult_done(mult_done));

   // any failure that is not a wrong value ends the run here
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("[FAIL] %0t ns op %s: %s is %0h, expected %0h",
                  $time, op.name(), what, actual, expected);
         $display("FAIL: see errors above");
         $fatal(1, "value mismatch");
      end
   endtask

   // buf with zero operands touches neither the register nor the multiplier
   task automatic idle_cycle();
      @(posedge clk);
      op       <= op_buf;
      data_in1 <= '0;
      data_in2 <= '0;
   endtask

   task automatic run_line(input byte mode, input logic [3:0] code, input logic [7:0] a,
                           input logic [7:0] b, input logic [7:0] expected);
      int waited;  // rising edges seen after the drive edge
      waited = 0;
      @(posedge clk);
      op       <= alu_op_e'(code);
      data_in1 <= a;
      data_in2 <= b;
      case (mode)
         "C": begin
            @(negedge clk);  // inputs and state are settled mid cycle
            check_value(32'(data_out), 32'(expected), "data_out");
            check_value(32'(mult_done), 32'd0, "mult_done");
         end
         "S": begin
            @(posedge clk);  // the DUT takes this one edge with the line's op
            @(negedge clk);
            check_value(32'(data_out), 32'(expected), "data_out after one edge");
            check_value(32'(mult_done), 32'd0, "mult_done");
         end
         "M": begin
            @(negedge clk);
            while (!mult_done && waited < MULT_TIMEOUT) begin
               check_value(32'(data_out), 32'd0, "data_out before mult_done");
               @(posedge clk);
               waited++;
               @(negedge clk);
            end
            if (!mult_done) begin
               abort_run($sformatf("timeout: mult_done never rose within %0d cycles",
                                   MULT_TIMEOUT));
            end
            // a fresh run needs exactly one edge per multiplier bit
            check_value(32'(waited), 32'(`ALU_MULT_CYCLES), "cycles until mult_done");
            check_value(32'(data_out), 32'(expected), "product low byte");
         end
         default: begin
            abort_run($sformatf("trace line has an unknown mode letter %c", mode));
         end
      endcase
   endtask

   initial begin
      string       line;
      byte         mode;
      byte         prev_mode;
      logic [31:0] code;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] expected;
      int          fields;
      int          gap;

      void'($urandom(32'h6c04a211));  // seeded once, only the gaps are random
      rst_n     = 1'b0;
      op        = op_buf;
      data_in1  = '0;
      data_in2  = '0;
      lines_run = 0;
      prev_mode = "C";

      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      trace_fd = $fopen("alu_trace.txt", "r");
      if (trace_fd == 0) begin
         abort_run("could not open alu_trace.txt for reading");
      end

      while (!$feof(trace_fd)) begin
         if ($fgets(line, trace_fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
               fields = $sscanf(line, "%c %h %h %h %h", mode, code, a, b, expected);
               if (fields != 5) begin
                  abort_run($sformatf("trace line could not be parsed: %s", line));
               end
               gap = $urandom % MAX_GAP;
               if (prev_mode != "C" && gap == 0) begin
                  gap = 1;  // op 4 has to drop for a cycle so the next run starts clean
               end
               repeat (gap) idle_cycle();
               run_line(mode, code[3:0], a[7:0], b[7:0], expected[7:0]);
               lines_run++;
               prev_mode = mode;
            end
         end
      end
      $fclose(trace_fd);

      if (lines_run > 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         $display("the trace file held no operation lines");
         $display("FAIL: see errors above");
         $fatal(1, "empty trace");
      end
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
alu_op_pkg.sv
alu_data_pkg.sv
op_demux.sv
result_mux.sv
gate_bank.sv
shift_add_mult.sv
dec_register.sv
alu.sv
tb_alu.sv
